//--- src/fpsu_consts.svh
`ifndef FPSU_CONSTS_SVH
`define FPSU_CONSTS_SVH

// data widths
`define FPSU_LANE_W 32
`define FPSU_VEC_W 64
`define FPSU_FLAGS_W 4

// op word, opcode sits in the low bits
`define FPSU_OP_W 12
`define FPSU_OPC_W 8

// opcodes
`define FPSU_OP_AND 8'h10
`define FPSU_OP_OR 8'h11
`define FPSU_OP_XOR 8'h12
`define FPSU_OP_ANDN 8'h13
`define FPSU_OP_PERM 8'h20
`define FPSU_OP_CMPEQ 8'h30
`define FPSU_OP_CMPLT 8'h31

// modifier bits above the opcode
`define FPSU_BIT_IMM 8
`define FPSU_BIT_COPYA 9
`define FPSU_BIT_SWAP 10
`define FPSU_BIT_DUP 11

// operand forward select codes
`define FPSU_FWD_REG 2'd0
`define FPSU_FWD_BUS0 2'd1
`define FPSU_FWD_BUS1 2'd2
`define FPSU_FWD_OWN 2'd3

`endif

//--- src/fpsu_pkg.sv
`include "fpsu_consts.svh"

package fpsu_pkg;

  // one lane, and the two-lane operand (index 1 is the high lane)
  typedef logic [`FPSU_LANE_W-1:0] lane_t;
  typedef lane_t [1:0] vec_t;

  typedef logic [`FPSU_OP_W-1:0] op_t;

  typedef enum logic [1:0] {
    cls_none  = 2'd0,
    cls_logic = 2'd1,
    cls_perm  = 2'd2,
    cls_cmp   = 2'd3
  } op_class_t;

  // lane-wise logic operator
  typedef enum logic [1:0] {
    sel_and  = 2'd0,
    sel_or   = 2'd1,
    sel_xor  = 2'd2,
    sel_andn = 2'd3
  } logic_sel_t;

  typedef logic [1:0] fwd_sel_t;

  // compare flag word
  typedef struct packed {
    logic lane1_true;
    logic lane0_true;
    logic any_true;
    logic all_true;
  } flags_t;

endpackage

//--- src/stage_delay.sv
`timescale 1ns/10ps

module stage_delay #(
  parameter type payload_t = logic,
  parameter int DEPTH = 1
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic [DEPTH-1:0] valid_q;
  payload_t data_q [DEPTH];

  // a stage only loads when valid arrives, so the payload holds between pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        data_q[i] <= '0;
      end
    end else begin
      valid_q[0] <= in_valid;
      if (in_valid) begin
        data_q[0] <= in_data;
      end
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
        if (valid_q[i-1]) begin
          data_q[i] <= data_q[i-1];
        end
      end
    end
  end

  assign out_valid = valid_q[DEPTH-1];
  assign out_data = data_q[DEPTH-1];

endmodule

//--- src/operand_forward.sv
`timescale 1ns/10ps
`include "fpsu_consts.svh"

module operand_forward import fpsu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  vec_t     reg_val,
  input  vec_t     bus0,
  input  vec_t     bus1,
  input  vec_t     own_bus,
  input  fwd_sel_t sel,
  input  logic     late,
  output vec_t     operand
);

  vec_t bus0_q;
  vec_t bus1_q;
  vec_t own_q;
  vec_t bus0_src;
  vec_t bus1_src;
  vec_t own_src;

  // one-cycle-old bus copies
  always_ff @(posedge clk) begin
    if (rst) begin
      bus0_q <= '0;
      bus1_q <= '0;
      own_q <= '0;
    end else begin
      bus0_q <= bus0;
      bus1_q <= bus1;
      own_q <= own_bus;
    end
  end

  assign bus0_src = late ? bus0_q : bus0;
  assign bus1_src = late ? bus1_q : bus1;
  assign own_src = late ? own_q : own_bus;

  always_comb begin
    case (sel)
      `FPSU_FWD_BUS0: operand = bus0_src;
      `FPSU_FWD_BUS1: operand = bus1_src;
      `FPSU_FWD_OWN:  operand = own_src;
      default:        operand = reg_val;
    endcase
  end

endmodule

//--- src/op_decode.sv
`timescale 1ns/10ps
`include "fpsu_consts.svh"

module op_decode import fpsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       issue_en,
  input  op_t        op,
  input  vec_t       a_fwd,
  input  vec_t       b_fwd,
  input  vec_t       b_imm,
  output logic       dec_valid,
  output op_class_t  op_class,
  output logic_sel_t logic_sel,
  output logic       copy_a,
  output logic       swap,
  output logic       dup,
  output logic       cmp_lt,
  output vec_t       op_a,
  output vec_t       op_b
);

  logic [`FPSU_OPC_W-1:0] opc;
  op_class_t cls_d;
  logic_sel_t lsel_d;

  assign opc = op[`FPSU_OPC_W-1:0];

  always_comb begin
    cls_d = cls_none;
    lsel_d = sel_and;
    case (opc)
      `FPSU_OP_AND: begin
        cls_d = cls_logic;
        lsel_d = sel_and;
      end
      `FPSU_OP_OR: begin
        cls_d = cls_logic;
        lsel_d = sel_or;
      end
      `FPSU_OP_XOR: begin
        cls_d = cls_logic;
        lsel_d = sel_xor;
      end
      `FPSU_OP_ANDN: begin
        cls_d = cls_logic;
        lsel_d = sel_andn;
      end
      `FPSU_OP_PERM: cls_d = cls_perm;
      `FPSU_OP_CMPEQ, `FPSU_OP_CMPLT: cls_d = cls_cmp;
      default: cls_d = cls_none;
    endcase
  end

  // unknown opcodes never raise dec_valid
  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
      op_class <= cls_none;
    end else begin
      dec_valid <= issue_en && (cls_d != cls_none);
      if (issue_en) begin
        op_class <= cls_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_en) begin
      logic_sel <= lsel_d;
      copy_a <= op[`FPSU_BIT_COPYA];
      swap <= op[`FPSU_BIT_SWAP];
      dup <= op[`FPSU_BIT_DUP];
      cmp_lt <= (opc == `FPSU_OP_CMPLT);
      op_a <= a_fwd;
      // immediate replaces the forwarded B
      op_b <= op[`FPSU_BIT_IMM] ? b_imm : b_fwd;
    end
  end

endmodule

//--- src/simd_execute.sv
`timescale 1ns/10ps
`include "fpsu_consts.svh"

module simd_execute import fpsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       dec_valid,
  input  op_class_t  op_class,
  input  logic_sel_t logic_sel,
  input  logic       copy_a,
  input  logic       swap,
  input  logic       dup,
  input  logic       cmp_lt,
  input  vec_t       op_a,
  input  vec_t       op_b,
  output logic       exe_valid,
  output logic       exe_is_cmp,
  output vec_t       exe_res,
  output flags_t     exe_flags
);

  vec_t logic_res;
  vec_t perm_src;
  vec_t perm_swp;
  vec_t perm_res;
  vec_t cmp_res;
  vec_t res_d;
  logic [1:0] lane_hit;
  flags_t flags_d;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      case (logic_sel)
        sel_and:  logic_res[i] = op_a[i] & op_b[i];
        sel_or:   logic_res[i] = op_a[i] | op_b[i];
        sel_xor:  logic_res[i] = op_a[i] ^ op_b[i];
        default:  logic_res[i] = op_a[i] & ~op_b[i];
      endcase
    end
  end

  // perm: merge or copy A, then swap, then dup
  always_comb begin
    perm_src[1] = op_a[1];
    perm_src[0] = copy_a ? op_a[0] : op_b[0];
    perm_swp = swap ? {perm_src[0], perm_src[1]} : perm_src;
    perm_res = dup ? {perm_swp[0], perm_swp[0]} : perm_swp;
  end

  // signed lane compare, masks of all ones
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (cmp_lt) begin
        lane_hit[i] = $signed(op_a[i]) < $signed(op_b[i]);
      end else begin
        lane_hit[i] = (op_a[i] == op_b[i]);
      end
      cmp_res[i] = {`FPSU_LANE_W{lane_hit[i]}};
    end
    flags_d.lane1_true = lane_hit[1];
    flags_d.lane0_true = lane_hit[0];
    flags_d.any_true = |lane_hit;
    flags_d.all_true = &lane_hit;
  end

  always_comb begin
    case (op_class)
      cls_logic: res_d = logic_res;
      cls_perm:  res_d = perm_res;
      cls_cmp:   res_d = cmp_res;
      default:   res_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid <= 1'b0;
      exe_is_cmp <= 1'b0;
    end else begin
      exe_valid <= dec_valid;
      exe_is_cmp <= dec_valid && (op_class == cls_cmp);
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      exe_res <= res_d;
    end
    // flags only move on a compare
    if (dec_valid && op_class == cls_cmp) begin
      exe_flags <= flags_d;
    end
  end

endmodule

//--- src/result_drive.sv
`timescale 1ns/10ps

module result_drive import fpsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       exe_valid,
  input  logic       exe_is_cmp,
  input  vec_t       exe_res,
  input  flags_t     exe_flags,
  input  logic [1:0] alt_sel,
  input  vec_t       alt_data0,
  input  vec_t       alt_data1,
  output vec_t       res_bus,
  output logic       res_valid,
  output flags_t     flags_out,
  output logic       flags_valid
);

  logic [1:0] alt_sel_q;
  vec_t res_q;

  stage_delay #(
    .payload_t(vec_t),
    .DEPTH(1)
  ) u_res_dly (
    .clk(clk),
    .rst(rst),
    .in_valid(exe_valid),
    .in_data(exe_res),
    .out_valid(res_valid),
    .out_data(res_q)
  );

  // flags trail the result by one cycle
  stage_delay #(
    .payload_t(flags_t),
    .DEPTH(2)
  ) u_flags_dly (
    .clk(clk),
    .rst(rst),
    .in_valid(exe_valid && exe_is_cmp),
    .in_data(exe_flags),
    .out_valid(flags_valid),
    .out_data(flags_out)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      alt_sel_q <= 2'b00;
    end else begin
      alt_sel_q <= alt_sel;
    end
  end

  // alternate data takes the bus, bit 0 first
  assign res_bus = alt_sel_q[0] ? alt_data0 :
                   alt_sel_q[1] ? alt_data1 : res_q;

endmodule

//--- src/fpsu_top.sv
`timescale 1ns/10ps

module fpsu_top import fpsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       issue_en,
  input  op_t        op,
  input  vec_t       a_reg,
  input  vec_t       b_reg,
  input  vec_t       b_imm,
  input  fwd_sel_t   a_fwd_sel,
  input  fwd_sel_t   b_fwd_sel,
  input  logic       a_fwd_late,
  input  logic       b_fwd_late,
  input  vec_t       bus0,
  input  vec_t       bus1,
  input  logic [1:0] alt_sel,
  input  vec_t       alt_data0,
  input  vec_t       alt_data1,
  output vec_t       res_bus,
  output logic       res_valid,
  output flags_t     flags_out,
  output logic       flags_valid
);

  vec_t a_fwd;
  vec_t b_fwd;

  logic dec_valid;
  op_class_t op_class;
  logic_sel_t logic_sel;
  logic copy_a;
  logic swap;
  logic dup;
  logic cmp_lt;
  vec_t op_a;
  vec_t op_b;

  logic exe_valid;
  logic exe_is_cmp;
  vec_t exe_res;
  flags_t exe_flags;

  // own result bus feeds back into both operand paths
  operand_forward u_fwd_a (
    .clk(clk),
    .rst(rst),
    .reg_val(a_reg),
    .bus0(bus0),
    .bus1(bus1),
    .own_bus(res_bus),
    .sel(a_fwd_sel),
    .late(a_fwd_late),
    .operand(a_fwd)
  );

  operand_forward u_fwd_b (
    .clk(clk),
    .rst(rst),
    .reg_val(b_reg),
    .bus0(bus0),
    .bus1(bus1),
    .own_bus(res_bus),
    .sel(b_fwd_sel),
    .late(b_fwd_late),
    .operand(b_fwd)
  );

  op_decode u_dec (
    .clk(clk),
    .rst(rst),
    .issue_en(issue_en),
    .op(op),
    .a_fwd(a_fwd),
    .b_fwd(b_fwd),
    .b_imm(b_imm),
    .dec_valid(dec_valid),
    .op_class(op_class),
    .logic_sel(logic_sel),
    .copy_a(copy_a),
    .swap(swap),
    .dup(dup),
    .cmp_lt(cmp_lt),
    .op_a(op_a),
    .op_b(op_b)
  );

  simd_execute u_exe (
    .clk(clk),
    .rst(rst),
    .dec_valid(dec_valid),
    .op_class(op_class),
    .logic_sel(logic_sel),
    .copy_a(copy_a),
    .swap(swap),
    .dup(dup),
    .cmp_lt(cmp_lt),
    .op_a(op_a),
    .op_b(op_b),
    .exe_valid(exe_valid),
    .exe_is_cmp(exe_is_cmp),
    .exe_res(exe_res),
    .exe_flags(exe_flags)
  );

  result_drive u_res (
    .clk(clk),
    .rst(rst),
    .exe_valid(exe_valid),
    .exe_is_cmp(exe_is_cmp),
    .exe_res(exe_res),
    .exe_flags(exe_flags),
    .alt_sel(alt_sel),
    .alt_data0(alt_data0),
    .alt_data1(alt_data1),
    .res_bus(res_bus),
    .res_valid(res_valid),
    .flags_out(flags_out),
    .flags_valid(flags_valid)
  );

endmodule

//--- testbench/tb_fpsu_model.svh
`ifndef TB_FPSU_MODEL_SVH
`define TB_FPSU_MODEL_SVH

// test and error counters
int err_cnt = 0;
int test_errs = 0;
int tests_run = 0;
int tests_failed = 0;

logic [15:0] lfsr = 16'd35170;

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

// one lfsr step per bit taken
function automatic logic [63:0] rand_bits(int n);
  logic [63:0] w;
  w = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr_step(lfsr);
    w = {w[62:0], lfsr[0]};
  end
  return w;
endfunction

// operand as the forwarding network should deliver it
function automatic logic [63:0] pick_operand(logic [63:0] reg_v, logic [1:0] sel, logic late);
  case (sel)
    `FPSU_FWD_BUS0: return late ? bus0_p : bus0;
    `FPSU_FWD_BUS1: return late ? bus1_p : bus1;
    `FPSU_FWD_OWN:  return late ? own_p : exp_bus;
    default:        return reg_v;
  endcase
endfunction

function automatic logic [63:0] logic_ref(logic [7:0] opc, logic [63:0] a, logic [63:0] b);
  case (opc)
    `FPSU_OP_AND: return a & b;
    `FPSU_OP_OR:  return a | b;
    `FPSU_OP_XOR: return a ^ b;
    default:      return a & ~b;
  endcase
endfunction

// merge or copy, then swap, then dup
function automatic logic [63:0] perm_ref(logic [11:0] o, logic [63:0] a, logic [63:0] b);
  logic [63:0] r;
  r = o[`FPSU_BIT_COPYA] ? a : {a[63:32], b[31:0]};
  if (o[`FPSU_BIT_SWAP]) begin
    r = {r[31:0], r[63:32]};
  end
  if (o[`FPSU_BIT_DUP]) begin
    r = {r[31:0], r[31:0]};
  end
  return r;
endfunction

function automatic logic [1:0] lane_hits(logic lt, logic [63:0] a, logic [63:0] b);
  logic [1:0] hit;
  if (lt) begin
    hit[1] = $signed(a[63:32]) < $signed(b[63:32]);
    hit[0] = $signed(a[31:0]) < $signed(b[31:0]);
  end else begin
    hit[1] = (a[63:32] == b[63:32]);
    hit[0] = (a[31:0] == b[31:0]);
  end
  return hit;
endfunction

`endif

//--- testbench/tb_fpsu.sv
`timescale 1ns/10ps
`include "fpsu_consts.svh"

module tb_fpsu import fpsu_pkg::*; ();

  localparam int N_LOGIC = 32;
  localparam int N_PERM = 16;
  localparam int N_CMP = 24;
  localparam int N_FWD = 24;
  localparam int DRAIN = 6;
  // reset idle, forward chain and alt test have fixed lengths
  localparam int RUN_CYCLES = 5 + 8 + N_LOGIC + N_PERM + N_CMP + N_FWD + 8 + 14 + 5 * DRAIN;

  logic clk;
  logic rst;
  logic issue_en;
  op_t op;
  vec_t a_reg;
  vec_t b_reg;
  vec_t b_imm;
  fwd_sel_t a_fwd_sel;
  fwd_sel_t b_fwd_sel;
  logic a_fwd_late;
  logic b_fwd_late;
  vec_t bus0;
  vec_t bus1;
  logic [1:0] alt_sel;
  vec_t alt_data0;
  vec_t alt_data1;
  vec_t res_bus;
  logic res_valid;
  flags_t flags_out;
  logic flags_valid;

  // expected outputs for the current cycle and model history
  logic exp_valid;
  logic exp_fvalid;
  logic [63:0] exp_bus;
  logic [63:0] last_res;
  logic [3:0] exp_flags;
  logic [63:0] bus0_p;
  logic [63:0] bus1_p;
  logic [63:0] own_p;
  logic [1:0] alt_p;
  logic [64:0] res_pipe[$];
  logic [4:0] flag_pipe[$];
  logic [7:0] logic_ops [4] = '{`FPSU_OP_AND, `FPSU_OP_OR, `FPSU_OP_XOR, `FPSU_OP_ANDN};

  `include "tb_fpsu_model.svh"

  fpsu_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] want);
    $display("error at %0d ns: %s is %h, expected %h", $time, name, got, want);
    err_cnt++;
    test_errs++;
  endtask

  assert property (@(posedge clk) disable iff (rst) res_valid == exp_valid)
    else report_mismatch("res_valid", {63'd0, $sampled(res_valid)}, {63'd0, $sampled(exp_valid)});
  assert property (@(posedge clk) disable iff (rst) res_bus == exp_bus)
    else report_mismatch("res_bus", $sampled(res_bus), $sampled(exp_bus));
  assert property (@(posedge clk) disable iff (rst) flags_valid == exp_fvalid)
    else report_mismatch("flags_valid", {63'd0, $sampled(flags_valid)},
                         {63'd0, $sampled(exp_fvalid)});
  assert property (@(posedge clk) disable iff (rst) flags_out == exp_flags)
    else report_mismatch("flags_out", {60'd0, $sampled(flags_out)}, {60'd0, $sampled(exp_flags)});

  task automatic finish_test(string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // expectation for this cycle, then the one for the op driven now
  task automatic model_cycle();
    logic [64:0] ev;
    logic [4:0] fev;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [1:0] hit;
    logic [7:0] opc;
    logic known;
    ev = res_pipe.pop_front();
    fev = flag_pipe.pop_front();
    exp_valid = ev[64];
    if (ev[64]) begin
      last_res = ev[63:0];
    end
    exp_fvalid = fev[4];
    if (fev[4]) begin
      exp_flags = fev[3:0];
    end
    exp_bus = alt_p[0] ? alt_data0 : (alt_p[1] ? alt_data1 : last_res);
    opc = op[7:0];
    a = pick_operand(a_reg, a_fwd_sel, a_fwd_late);
    b = op[`FPSU_BIT_IMM] ? b_imm : pick_operand(b_reg, b_fwd_sel, b_fwd_late);
    hit = lane_hits(opc == `FPSU_OP_CMPLT, a, b);
    known = 1'b1;
    case (opc)
      `FPSU_OP_AND, `FPSU_OP_OR, `FPSU_OP_XOR, `FPSU_OP_ANDN: r = logic_ref(opc, a, b);
      `FPSU_OP_PERM: r = perm_ref(op, a, b);
      `FPSU_OP_CMPEQ, `FPSU_OP_CMPLT: r = {{32{hit[1]}}, {32{hit[0]}}};
      default: begin
        r = '0;
        known = 1'b0;
      end
    endcase
    res_pipe.push_back({issue_en && known, r});
    flag_pipe.push_back({issue_en && (opc == `FPSU_OP_CMPEQ || opc == `FPSU_OP_CMPLT),
                         hit[1], hit[0], |hit, &hit});
    bus0_p = bus0;
    bus1_p = bus1;
    own_p = exp_bus;
    alt_p = alt_sel;
  endtask

  task automatic step();
    model_cycle();
    @(posedge clk);
    #2;
    issue_en = 1'b0;
    alt_sel = 2'b00;
  endtask

  task automatic idle(int n);
    repeat (n) step();
  endtask

  task automatic load_operands();
    a_reg = rand_bits(64);
    b_reg = rand_bits(64);
    b_imm = rand_bits(64);
  endtask

  initial begin
    #((RUN_CYCLES + 20) * 40);
    $display("timeout: run did not finish within %0d cycles", RUN_CYCLES + 20);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [63:0] rnd;
    rst = 1'b1;
    issue_en = 1'b0;
    op = '0;
    a_reg = '0;
    b_reg = '0;
    b_imm = '0;
    a_fwd_sel = `FPSU_FWD_REG;
    b_fwd_sel = `FPSU_FWD_REG;
    a_fwd_late = 1'b0;
    b_fwd_late = 1'b0;
    bus0 = '0;
    bus1 = '0;
    alt_sel = 2'b00;
    alt_data0 = '0;
    alt_data1 = '0;
    exp_valid = 1'b0;
    exp_fvalid = 1'b0;
    exp_bus = '0;
    last_res = '0;
    exp_flags = '0;
    bus0_p = '0;
    bus1_p = '0;
    own_p = '0;
    alt_p = 2'b00;
    // pipe depths match result and flag latency
    repeat (3) res_pipe.push_back('0);
    repeat (4) flag_pipe.push_back('0);
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    idle(8);
    finish_test("reset_idle");

    for (int i = 0; i < N_LOGIC; i++) begin
      load_operands();
      rnd = rand_bits(1);
      op = {3'b000, rnd[0], logic_ops[i[1:0]]};
      issue_en = 1'b1;
      step();
    end
    idle(DRAIN);
    finish_test("logic_ops");

    // modifier bits walk all combinations including imm
    for (int i = 0; i < N_PERM; i++) begin
      load_operands();
      op = {i[3:0], `FPSU_OP_PERM};
      issue_en = 1'b1;
      step();
    end
    idle(DRAIN);
    finish_test("perm");

    for (int i = 0; i < N_CMP; i++) begin
      load_operands();
      rnd = rand_bits(2);
      if (rnd[0]) begin
        b_reg[0] = a_reg[0];
      end
      if (rnd[1]) begin
        b_reg[1] = a_reg[1];
      end
      op = {4'b0000, i[0] ? `FPSU_OP_CMPLT : `FPSU_OP_CMPEQ};
      // every fourth op is a logic op that must leave the flags alone
      if (i[1:0] == 2'd3) begin
        op = {4'b0000, `FPSU_OP_XOR};
      end
      issue_en = 1'b1;
      step();
    end
    idle(DRAIN);
    finish_test("compare");

    for (int i = 0; i < N_FWD; i++) begin
      load_operands();
      bus0 = rand_bits(64);
      bus1 = rand_bits(64);
      a_fwd_sel = i[1:0];
      a_fwd_late = i[2];
      b_fwd_sel = ~i[1:0];
      b_fwd_late = i[3];
      op = {4'b0000, logic_ops[i[1:0]]};
      issue_en = 1'b1;
      step();
    end
    a_fwd_sel = `FPSU_FWD_REG;
    b_fwd_sel = `FPSU_FWD_REG;
    a_fwd_late = 1'b0;
    b_fwd_late = 1'b0;
    load_operands();
    op = {4'b0000, `FPSU_OP_OR};
    issue_en = 1'b1;
    step();
    idle(3);
    // A takes the result that just completed, then its late copy
    load_operands();
    a_fwd_sel = `FPSU_FWD_OWN;
    op = {4'b0000, `FPSU_OP_XOR};
    issue_en = 1'b1;
    step();
    load_operands();
    a_fwd_late = 1'b1;
    op = {4'b0000, `FPSU_OP_AND};
    issue_en = 1'b1;
    step();
    a_fwd_sel = `FPSU_FWD_REG;
    a_fwd_late = 1'b0;
    idle(2 + DRAIN);
    finish_test("forward");

    alt_data0 = rand_bits(64);
    alt_data1 = rand_bits(64);
    load_operands();
    op = 12'h07f;
    issue_en = 1'b1;
    step();
    for (int i = 0; i < 6; i++) begin
      load_operands();
      op = {4'b0000, logic_ops[i[1:0]]};
      issue_en = 1'b1;
      alt_sel = i[1:0];
      step();
    end
    for (int i = 0; i < 7; i++) begin
      alt_data0 = rand_bits(64);
      alt_sel = i[1:0];
      op = 12'h000;
      issue_en = (i == 2);
      step();
    end
    idle(DRAIN);
    finish_test("alt_unknown");

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+src
+incdir+testbench
src/fpsu_pkg.sv
src/stage_delay.sv
src/operand_forward.sv
src/op_decode.sv
src/simd_execute.sv
src/result_drive.sv
src/fpsu_top.sv
testbench/tb_fpsu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fpsu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_fpsu \
  -Mdir obj_dir -o tb_fpsu

./obj_dir/tb_fpsu > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
exit 0
